//--- src/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// ----------------------------------------
// cache geometry
// ----------------------------------------
`define DC_PADDR_W     32
`define DC_LINE_BYTES  16
`define DC_BANKS       2
`define DC_SETS        8
`define DC_RD_PORTS    2

// address slicing from the byte offset up to the tag
`define DC_BANK_LO     4
`define DC_IDX_LO      5
`define DC_IDX_HI      7
`define DC_TAG_LO      8

`endif

//--- src/dcache_pkg.sv
`default_nettype none

`include "dcache_config.svh"

package dcache_pkg;

  // ----------------------------------------
  // address and line payloads
  // ----------------------------------------
  typedef logic [`DC_PADDR_W-1:0] paddr_t;

  typedef logic [`DC_LINE_BYTES*8-1:0] line_t;

  // one enable bit per line byte
  typedef logic [`DC_LINE_BYTES-1:0] be_t;

  // upper address bits above the set index
  typedef logic [`DC_PADDR_W-`DC_TAG_LO-1:0] tag_t;

  // ----------------------------------------
  // bank and set selection
  // ----------------------------------------
  // one-hot where bit b names bank b
  typedef logic [`DC_BANKS-1:0] bank_sel_t;

  typedef logic [$clog2(`DC_BANKS)-1:0] bank_id_t;

  typedef logic [`DC_IDX_HI-`DC_IDX_LO:0] set_idx_t;

endpackage

`default_nettype wire

//--- src/dcache_wr_merge.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_wr_merge (
  input  wire                    i_clk,
  input  wire                    i_reset_n,
  input  wire                    i_st_valid,
  input  wire dcache_pkg::paddr_t i_st_paddr,
  input  wire dcache_pkg::line_t i_st_data,
  input  wire dcache_pkg::be_t   i_st_be,
  input  wire                    i_rf_valid,
  input  wire dcache_pkg::paddr_t i_rf_paddr,
  input  wire dcache_pkg::line_t i_rf_data,
  input  wire                    i_mg_valid,
  input  wire dcache_pkg::line_t i_mg_data,
  input  wire dcache_pkg::be_t   i_mg_be,
  input  wire dcache_pkg::bank_sel_t i_st_hit_bank,
  output logic                   o_wr_valid,
  output logic                   o_wr_fill,
  output dcache_pkg::paddr_t     o_wr_paddr,
  output dcache_pkg::line_t      o_wr_data,
  output dcache_pkg::be_t        o_wr_be,
  output logic                   o_st_resp_valid,
  output logic                   o_st_hit,
  output logic                   o_st_miss,
  output logic                   o_st_conflict
);

  import dcache_pkg::*;

  line_t    w_rf_merged;
  logic     r_st_valid;
  logic     r_st_conflict;
  bank_id_t r_st_bank;
  logic     w_st_bank_hit;

  // pending store bytes override the incoming refill bytes
  always_comb begin
    for (int b = 0; b < `DC_LINE_BYTES; b++) begin
      w_rf_merged[b*8 +: 8] = (i_mg_valid && i_mg_be[b]) ? i_mg_data[b*8 +: 8]
                                                          : i_rf_data[b*8 +: 8];
    end
  end

  // ----------------------------------------
  // write request with refill priority
  // ----------------------------------------
  assign o_wr_valid = i_rf_valid | i_st_valid;
  assign o_wr_fill  = i_rf_valid;
  assign o_wr_paddr = i_rf_valid ? i_rf_paddr  : i_st_paddr;
  assign o_wr_data  = i_rf_valid ? w_rf_merged : i_st_data;
  assign o_wr_be    = i_rf_valid ? '1          : i_st_be;

  // s1 store response
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_st_valid    <= 1'b0;
      r_st_conflict <= 1'b0;
      r_st_bank     <= '0;
    end else begin
      r_st_valid    <= i_st_valid;
      r_st_conflict <= i_st_valid & i_rf_valid;
      r_st_bank     <= i_st_paddr[`DC_BANK_LO];
    end
  end

  assign w_st_bank_hit   = i_st_hit_bank[r_st_bank];
  assign o_st_resp_valid = r_st_valid;
  assign o_st_conflict   = r_st_conflict;
  assign o_st_hit        = r_st_valid & ~r_st_conflict & w_st_bank_hit;
  assign o_st_miss       = r_st_valid & ~r_st_conflict & ~w_st_bank_hit;

endmodule

`default_nettype wire

//--- src/dcache_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_bank (
  input  wire                        i_clk,
  input  wire                        i_reset_n,
  input  wire dcache_pkg::bank_id_t  i_bank,
  input  wire                        i_wr_valid,
  input  wire                        i_wr_fill,
  input  wire dcache_pkg::paddr_t    i_wr_paddr,
  input  wire dcache_pkg::line_t     i_wr_data,
  input  wire dcache_pkg::be_t       i_wr_be,
  output logic                       o_st_hit,
  input  wire [`DC_RD_PORTS-1:0]     i_rd_valid,
  input  wire dcache_pkg::paddr_t    i_rd_paddr [`DC_RD_PORTS],
  output logic [`DC_RD_PORTS-1:0]    o_rd_hit,
  output logic [`DC_RD_PORTS-1:0]    o_rd_miss,
  output logic [`DC_RD_PORTS-1:0]    o_rd_conflict,
  output dcache_pkg::line_t          o_rd_data [`DC_RD_PORTS]
);

  import dcache_pkg::*;

  // arrays
  tag_t                r_tag  [`DC_SETS];
  line_t               r_data [`DC_SETS];
  logic [`DC_SETS-1:0] r_valid;

  // write side
  logic     w_wr_sel;
  set_idx_t w_wr_idx;
  tag_t     w_wr_tag;
  logic     w_wr_tag_match;
  logic     w_wr_en;
  be_t      w_wr_be;

  // read side
  logic [`DC_RD_PORTS-1:0] w_rd_grant;
  paddr_t                  w_rd_paddr;
  set_idx_t                w_rd_idx;
  tag_t                    w_rd_tag;
  logic                    w_rd_hit;
  logic [`DC_RD_PORTS-1:0] r_rd_grant;
  logic [`DC_RD_PORTS-1:0] r_rd_conflict;
  logic                    r_rd_hit;
  line_t                   r_rd_data;

  // ----------------------------------------
  // write update
  // ----------------------------------------
  assign w_wr_sel       = i_wr_valid && (i_wr_paddr[`DC_BANK_LO] == i_bank);
  assign w_wr_idx       = i_wr_paddr[`DC_IDX_HI:`DC_IDX_LO];
  assign w_wr_tag       = i_wr_paddr[`DC_PADDR_W-1:`DC_TAG_LO];
  assign w_wr_tag_match = r_valid[w_wr_idx] && (r_tag[w_wr_idx] == w_wr_tag);

  // stores only land on a resident line
  assign w_wr_en = w_wr_sel && (i_wr_fill || w_wr_tag_match);
  assign w_wr_be = i_wr_fill ? '1 : i_wr_be;

  always_ff @(posedge i_clk) begin
    if (w_wr_sel && i_wr_fill) begin
      r_tag[w_wr_idx] <= w_wr_tag;
    end
    for (int b = 0; b < `DC_LINE_BYTES; b++) begin
      if (w_wr_en && w_wr_be[b]) begin
        r_data[w_wr_idx][b*8 +: 8] <= i_wr_data[b*8 +: 8];
      end
    end
  end

  // ----------------------------------------
  // read arbitration where the lowest port wins
  // ----------------------------------------
  assign w_rd_grant = i_rd_valid & (~i_rd_valid + 1'b1);

  always_comb begin
    w_rd_paddr = '0;
    for (int p = 0; p < `DC_RD_PORTS; p++) begin
      if (w_rd_grant[p]) begin
        w_rd_paddr = i_rd_paddr[p];
      end
    end
  end

  assign w_rd_idx = w_rd_paddr[`DC_IDX_HI:`DC_IDX_LO];
  assign w_rd_tag = w_rd_paddr[`DC_PADDR_W-1:`DC_TAG_LO];
  assign w_rd_hit = r_valid[w_rd_idx] && (r_tag[w_rd_idx] == w_rd_tag);

  // array sampled before this cycle's write lands
  always_ff @(posedge i_clk) begin
    r_rd_data <= r_data[w_rd_idx];
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid       <= '0;
      r_rd_grant    <= '0;
      r_rd_conflict <= '0;
      r_rd_hit      <= 1'b0;
      o_st_hit      <= 1'b0;
    end else begin
      if (w_wr_sel && i_wr_fill) begin
        r_valid[w_wr_idx] <= 1'b1;
      end
      r_rd_grant    <= w_rd_grant;
      r_rd_conflict <= i_rd_valid & ~w_rd_grant;
      r_rd_hit      <= w_rd_hit;
      o_st_hit      <= w_wr_sel && !i_wr_fill && w_wr_tag_match;
    end
  end

  // s1 response with one line shared by all ports
  assign o_rd_hit      = r_rd_grant & {`DC_RD_PORTS{r_rd_hit}};
  assign o_rd_miss     = r_rd_grant & {`DC_RD_PORTS{~r_rd_hit}};
  assign o_rd_conflict = r_rd_conflict;

  for (genvar p = 0; p < `DC_RD_PORTS; p++) begin : g_rd_data
    assign o_rd_data[p] = r_rd_data;
  end

endmodule

`default_nettype wire

//--- src/dcache_rd_route.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_rd_route (
  input  wire                          i_clk,
  input  wire                          i_reset_n,
  input  wire [`DC_RD_PORTS-1:0]       i_rd_valid,
  input  wire dcache_pkg::paddr_t      i_rd_paddr [`DC_RD_PORTS],
  output dcache_pkg::bank_sel_t        o_bank_rd_valid [`DC_RD_PORTS],
  input  wire [`DC_RD_PORTS-1:0]       i_bank_hit [`DC_BANKS],
  input  wire [`DC_RD_PORTS-1:0]       i_bank_miss [`DC_BANKS],
  input  wire [`DC_RD_PORTS-1:0]       i_bank_conflict [`DC_BANKS],
  input  wire dcache_pkg::line_t       i_bank_data [`DC_BANKS][`DC_RD_PORTS],
  output logic [`DC_RD_PORTS-1:0]      o_rd_hit,
  output logic [`DC_RD_PORTS-1:0]      o_rd_miss,
  output logic [`DC_RD_PORTS-1:0]      o_rd_conflict,
  output dcache_pkg::line_t            o_rd_data [`DC_RD_PORTS]
);

  import dcache_pkg::*;

  // which bank each port's s1 response comes from
  bank_sel_t r_bank_sel [`DC_RD_PORTS];

  // ----------------------------------------
  // s0 bank decode
  // ----------------------------------------
  for (genvar p = 0; p < `DC_RD_PORTS; p++) begin : g_port
    for (genvar b = 0; b < `DC_BANKS; b++) begin : g_bank
      assign o_bank_rd_valid[p][b] = i_rd_valid[p] &&
                                     (i_rd_paddr[p][`DC_BANK_LO] == bank_id_t'(b));
    end

    always_ff @(posedge i_clk, negedge i_reset_n) begin
      if (!i_reset_n) begin
        r_bank_sel[p] <= '0;
      end else begin
        r_bank_sel[p] <= o_bank_rd_valid[p];
      end
    end
  end

  // ----------------------------------------
  // s1 response select
  // ----------------------------------------
  // mask is one-hot or zero, so a plain OR picks the bank
  always_comb begin
    for (int p = 0; p < `DC_RD_PORTS; p++) begin
      o_rd_hit[p]      = 1'b0;
      o_rd_miss[p]     = 1'b0;
      o_rd_conflict[p] = 1'b0;
      o_rd_data[p]     = '0;
      for (int b = 0; b < `DC_BANKS; b++) begin
        o_rd_hit[p]      = o_rd_hit[p]      | (r_bank_sel[p][b] & i_bank_hit[b][p]);
        o_rd_miss[p]     = o_rd_miss[p]     | (r_bank_sel[p][b] & i_bank_miss[b][p]);
        o_rd_conflict[p] = o_rd_conflict[p] | (r_bank_sel[p][b] & i_bank_conflict[b][p]);
        o_rd_data[p]     = o_rd_data[p] |
                           ({(`DC_LINE_BYTES*8){r_bank_sel[p][b]}} & i_bank_data[b][p]);
      end
    end
  end

endmodule

`default_nettype wire

//--- src/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_top (
  input  wire                       i_clk,
  input  wire                       i_reset_n,
  // load ports
  input  wire [`DC_RD_PORTS-1:0]    i_rd_valid,
  input  wire dcache_pkg::paddr_t   i_rd_paddr [`DC_RD_PORTS],
  output logic [`DC_RD_PORTS-1:0]   o_rd_hit,
  output logic [`DC_RD_PORTS-1:0]   o_rd_miss,
  output logic [`DC_RD_PORTS-1:0]   o_rd_conflict,
  output dcache_pkg::line_t         o_rd_data [`DC_RD_PORTS],
  // store port
  input  wire                       i_st_valid,
  input  wire dcache_pkg::paddr_t   i_st_paddr,
  input  wire dcache_pkg::line_t    i_st_data,
  input  wire dcache_pkg::be_t      i_st_be,
  output logic                      o_st_resp_valid,
  output logic                      o_st_hit,
  output logic                      o_st_miss,
  output logic                      o_st_conflict,
  // refill with store merge overlay
  input  wire                       i_rf_valid,
  input  wire dcache_pkg::paddr_t   i_rf_paddr,
  input  wire dcache_pkg::line_t    i_rf_data,
  input  wire                       i_mg_valid,
  input  wire dcache_pkg::line_t    i_mg_data,
  input  wire dcache_pkg::be_t      i_mg_be
);

  import dcache_pkg::*;

  // ----------------------------------------
  // shared write request
  // ----------------------------------------
  logic      w_wr_valid;
  logic      w_wr_fill;
  paddr_t    w_wr_paddr;
  line_t     w_wr_data;
  be_t       w_wr_be;
  bank_sel_t w_st_hit_bank;

  // per-port bank masks and their per-bank view
  bank_sel_t               w_port_bank_sel [`DC_RD_PORTS];
  logic [`DC_RD_PORTS-1:0] w_bank_rd_valid [`DC_BANKS];
  logic [`DC_RD_PORTS-1:0] w_bank_hit      [`DC_BANKS];
  logic [`DC_RD_PORTS-1:0] w_bank_miss     [`DC_BANKS];
  logic [`DC_RD_PORTS-1:0] w_bank_conflict [`DC_BANKS];
  line_t                   w_bank_data     [`DC_BANKS][`DC_RD_PORTS];

  dcache_wr_merge u_wr_merge (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_st_valid      (i_st_valid),
    .i_st_paddr      (i_st_paddr),
    .i_st_data       (i_st_data),
    .i_st_be         (i_st_be),
    .i_rf_valid      (i_rf_valid),
    .i_rf_paddr      (i_rf_paddr),
    .i_rf_data       (i_rf_data),
    .i_mg_valid      (i_mg_valid),
    .i_mg_data       (i_mg_data),
    .i_mg_be         (i_mg_be),
    .i_st_hit_bank   (w_st_hit_bank),
    .o_wr_valid      (w_wr_valid),
    .o_wr_fill       (w_wr_fill),
    .o_wr_paddr      (w_wr_paddr),
    .o_wr_data       (w_wr_data),
    .o_wr_be         (w_wr_be),
    .o_st_resp_valid (o_st_resp_valid),
    .o_st_hit        (o_st_hit),
    .o_st_miss       (o_st_miss),
    .o_st_conflict   (o_st_conflict)
  );

  for (genvar b = 0; b < `DC_BANKS; b++) begin : g_bank
    for (genvar p = 0; p < `DC_RD_PORTS; p++) begin : g_port
      assign w_bank_rd_valid[b][p] = w_port_bank_sel[p][b];
    end

    dcache_bank u_bank (
      .i_clk         (i_clk),
      .i_reset_n     (i_reset_n),
      .i_bank        (bank_id_t'(b)),
      .i_wr_valid    (w_wr_valid),
      .i_wr_fill     (w_wr_fill),
      .i_wr_paddr    (w_wr_paddr),
      .i_wr_data     (w_wr_data),
      .i_wr_be       (w_wr_be),
      .o_st_hit      (w_st_hit_bank[b]),
      .i_rd_valid    (w_bank_rd_valid[b]),
      .i_rd_paddr    (i_rd_paddr),
      .o_rd_hit      (w_bank_hit[b]),
      .o_rd_miss     (w_bank_miss[b]),
      .o_rd_conflict (w_bank_conflict[b]),
      .o_rd_data     (w_bank_data[b])
    );
  end

  dcache_rd_route u_rd_route (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_rd_valid      (i_rd_valid),
    .i_rd_paddr      (i_rd_paddr),
    .o_bank_rd_valid (w_port_bank_sel),
    .i_bank_hit      (w_bank_hit),
    .i_bank_miss     (w_bank_miss),
    .i_bank_conflict (w_bank_conflict),
    .i_bank_data     (w_bank_data),
    .o_rd_hit        (o_rd_hit),
    .o_rd_miss       (o_rd_miss),
    .o_rd_conflict   (o_rd_conflict),
    .o_rd_data       (o_rd_data)
  );

endmodule

`default_nettype wire

//--- sim/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module tb_dcache;

  import dcache_pkg::*;

  // cycles for reset, the five directed tests and the random run
  localparam int TEST_CYCLES    = 2 + 2 + 3 + 5 + 5 + 3 + 100;
  localparam int TIMEOUT_CYCLES = TEST_CYCLES + 280;

  logic                    clk;
  logic                    reset_n;
  logic [`DC_RD_PORTS-1:0] rd_valid;
  paddr_t                  rd_paddr [`DC_RD_PORTS];
  logic [`DC_RD_PORTS-1:0] rd_hit;
  logic [`DC_RD_PORTS-1:0] rd_miss;
  logic [`DC_RD_PORTS-1:0] rd_conflict;
  line_t                   rd_data [`DC_RD_PORTS];
  logic                    st_valid;
  paddr_t                  st_paddr;
  line_t                   st_data;
  be_t                     st_be;
  logic                    st_resp_valid;
  logic                    st_hit;
  logic                    st_miss;
  logic                    st_conflict;
  logic                    rf_valid;
  paddr_t                  rf_paddr;
  line_t                   rf_data;
  logic                    mg_valid;
  line_t                   mg_data;
  be_t                     mg_be;

  // reference model with one entry per bank and set
  tag_t  m_tag   [`DC_BANKS][`DC_SETS];
  logic  m_valid [`DC_BANKS][`DC_SETS];
  line_t m_line  [`DC_BANKS][`DC_SETS];

  logic [31:0] rng_state;
  int          cycle_count = 0;
  int          err_count;
  int          tests_passed;
  int          tests_failed;

  dcache_top u_dut (
    .i_clk           (clk),
    .i_reset_n       (reset_n),
    .i_rd_valid      (rd_valid),
    .i_rd_paddr      (rd_paddr),
    .o_rd_hit        (rd_hit),
    .o_rd_miss       (rd_miss),
    .o_rd_conflict   (rd_conflict),
    .o_rd_data       (rd_data),
    .i_st_valid      (st_valid),
    .i_st_paddr      (st_paddr),
    .i_st_data       (st_data),
    .i_st_be         (st_be),
    .o_st_resp_valid (st_resp_valid),
    .o_st_hit        (st_hit),
    .o_st_miss       (st_miss),
    .o_st_conflict   (st_conflict),
    .i_rf_valid      (rf_valid),
    .i_rf_paddr      (rf_paddr),
    .i_rf_data       (rf_data),
    .i_mg_valid      (mg_valid),
    .i_mg_data       (mg_data),
    .i_mg_be         (mg_be)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic line_t random_line();
    return {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
  endfunction

  function automatic paddr_t make_addr(tag_t tag, set_idx_t idx, bank_id_t bank,
                                       logic [3:0] off);
    return {tag, idx, bank, off};
  endfunction

  // two tags over sets 0..3 of both banks, so lines get reused
  function automatic paddr_t random_addr();
    logic [31:0] r;
    r = lcg_next();
    return make_addr({23'h20, r[31]}, {1'b0, r[30:29]}, r[28], r[27:24]);
  endfunction

  function automatic logic resident(paddr_t a);
    bank_id_t bk;
    set_idx_t ix;
    bk = a[`DC_BANK_LO];
    ix = a[`DC_IDX_HI:`DC_IDX_LO];
    return m_valid[bk][ix] && (m_tag[bk][ix] == a[`DC_PADDR_W-1:`DC_TAG_LO]);
  endfunction

  function automatic line_t overlay_bytes(line_t base, line_t upd, be_t be);
    line_t res;
    res = base;
    for (int b = 0; b < `DC_LINE_BYTES; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = upd[b*8 +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error at %0t ns: %s expected %b, actual %b", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_line(input string name, input line_t exp, input line_t act);
    if (act !== exp) begin
      $display("Error at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic clear_inputs();
    rd_valid = '0;
    for (int p = 0; p < `DC_RD_PORTS; p++) begin
      rd_paddr[p] = '0;
    end
    st_valid = 1'b0;
    st_paddr = '0;
    st_data  = '0;
    st_be    = '0;
    rf_valid = 1'b0;
    rf_paddr = '0;
    rf_data  = '0;
    mg_valid = 1'b0;
    mg_data  = '0;
    mg_be    = '0;
  endtask

  // one s0 cycle checked against the model at the next falling edge
  task automatic run_cycle();
    logic [`DC_RD_PORTS-1:0] e_hit;
    logic [`DC_RD_PORTS-1:0] e_miss;
    logic [`DC_RD_PORTS-1:0] e_conf;
    line_t                   e_data [`DC_RD_PORTS];
    bank_sel_t               bank_used;
    logic                    e_st_valid;
    logic                    e_st_conf;
    logic                    e_st_hit;
    bank_id_t                bk;
    set_idx_t                ix;
    e_hit     = '0;
    e_miss    = '0;
    e_conf    = '0;
    bank_used = '0;
    for (int p = 0; p < `DC_RD_PORTS; p++) begin
      e_data[p] = '0;
      if (rd_valid[p]) begin
        bk = rd_paddr[p][`DC_BANK_LO];
        ix = rd_paddr[p][`DC_IDX_HI:`DC_IDX_LO];
        if (bank_used[bk]) begin
          e_conf[p] = 1'b1;
        end else begin
          bank_used[bk] = 1'b1;
          e_hit[p]      = resident(rd_paddr[p]);
          e_miss[p]     = !e_hit[p];
          e_data[p]     = m_line[bk][ix];
        end
      end
    end
    e_st_valid = st_valid;
    e_st_conf  = st_valid && rf_valid;
    e_st_hit   = st_valid && !rf_valid && resident(st_paddr);
    if (rf_valid) begin
      bk = rf_paddr[`DC_BANK_LO];
      ix = rf_paddr[`DC_IDX_HI:`DC_IDX_LO];
      m_valid[bk][ix] = 1'b1;
      m_tag[bk][ix]   = rf_paddr[`DC_PADDR_W-1:`DC_TAG_LO];
      m_line[bk][ix]  = mg_valid ? overlay_bytes(rf_data, mg_data, mg_be) : rf_data;
    end else if (st_valid && resident(st_paddr)) begin
      bk = st_paddr[`DC_BANK_LO];
      ix = st_paddr[`DC_IDX_HI:`DC_IDX_LO];
      m_line[bk][ix] = overlay_bytes(m_line[bk][ix], st_data, st_be);
    end
    @(posedge clk);
    @(negedge clk);
    for (int p = 0; p < `DC_RD_PORTS; p++) begin
      check_flag($sformatf("o_rd_hit[%0d]", p), e_hit[p], rd_hit[p]);
      check_flag($sformatf("o_rd_miss[%0d]", p), e_miss[p], rd_miss[p]);
      check_flag($sformatf("o_rd_conflict[%0d]", p), e_conf[p], rd_conflict[p]);
      if (e_hit[p]) begin
        check_line($sformatf("o_rd_data[%0d]", p), e_data[p], rd_data[p]);
      end
    end
    check_flag("o_st_resp_valid", e_st_valid, st_resp_valid);
    check_flag("o_st_conflict", e_st_conf, st_conflict);
    check_flag("o_st_hit", e_st_hit, st_hit);
    check_flag("o_st_miss", e_st_valid && !e_st_conf && !e_st_hit, st_miss);
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      tests_passed++;
      $display("test %-14s ok", name);
    end else begin
      tests_failed++;
      $display("test %-14s failed with %0d errors", name, err_count - errs_before);
    end
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic test_reset_miss();
    int e0;
    e0 = err_count;
    clear_inputs();
    rd_valid    = 2'b11;
    rd_paddr[0] = make_addr(24'h1, 3'd0, 1'b0, 4'h0);
    rd_paddr[1] = make_addr(24'h2, 3'd5, 1'b1, 4'h8);
    st_valid    = 1'b1;
    st_paddr    = make_addr(24'h1, 3'd0, 1'b0, 4'h4);
    st_data     = random_line();
    st_be       = '1;
    run_cycle();
    clear_inputs();
    rd_valid    = 2'b11;
    rd_paddr[0] = make_addr(24'h7, 3'd7, 1'b1, 4'h0);
    rd_paddr[1] = make_addr(24'h3, 3'd2, 1'b0, 4'h0);
    run_cycle();
    finish_test("reset_miss", e0);
  endtask

  task automatic test_refill_hit();
    int     e0;
    paddr_t a;
    e0 = err_count;
    a  = make_addr(24'h5, 3'd3, 1'b0, 4'h0);
    clear_inputs();
    rf_valid = 1'b1;
    rf_paddr = a;
    rf_data  = random_line();
    run_cycle();
    clear_inputs();
    rd_valid    = 2'b01;
    rd_paddr[0] = a;
    run_cycle();
    // same set with another tag
    clear_inputs();
    rd_valid    = 2'b10;
    rd_paddr[1] = make_addr(24'h6, 3'd3, 1'b0, 4'h0);
    run_cycle();
    finish_test("refill_hit", e0);
  endtask

  task automatic test_store_bytes();
    int     e0;
    paddr_t a;
    e0 = err_count;
    a  = make_addr(24'h9, 3'd2, 1'b1, 4'h0);
    clear_inputs();
    rf_valid = 1'b1;
    rf_paddr = a;
    rf_data  = random_line();
    run_cycle();
    clear_inputs();
    st_valid = 1'b1;
    st_paddr = a;
    st_data  = random_line();
    st_be    = 16'h00f3;
    run_cycle();
    clear_inputs();
    rd_valid    = 2'b10;
    rd_paddr[1] = a;
    run_cycle();
    clear_inputs();
    st_valid = 1'b1;
    st_paddr = make_addr(24'ha, 3'd2, 1'b1, 4'h0);
    st_data  = random_line();
    st_be    = '1;
    run_cycle();
    clear_inputs();
    rd_valid    = 2'b01;
    rd_paddr[0] = a;
    run_cycle();
    finish_test("store_bytes", e0);
  endtask

  task automatic test_port_conflict();
    int     e0;
    paddr_t d;
    paddr_t e;
    e0 = err_count;
    d  = make_addr(24'h11, 3'd1, 1'b0, 4'h0);
    e  = make_addr(24'h12, 3'd1, 1'b1, 4'h0);
    clear_inputs();
    rf_valid = 1'b1;
    rf_paddr = d;
    rf_data  = random_line();
    run_cycle();
    rf_paddr = e;
    rf_data  = random_line();
    run_cycle();
    clear_inputs();
    rd_valid    = 2'b11;
    rd_paddr[0] = d;
    rd_paddr[1] = d;
    run_cycle();
    rd_paddr[1] = e;
    run_cycle();
    rd_paddr[0] = e;
    rd_paddr[1] = d;
    run_cycle();
    finish_test("port_conflict", e0);
  endtask

  task automatic test_refill_merge();
    int     e0;
    paddr_t f;
    paddr_t g;
    e0 = err_count;
    f  = make_addr(24'h21, 3'd6, 1'b0, 4'h0);
    g  = make_addr(24'h22, 3'd6, 1'b1, 4'h0);
    clear_inputs();
    rf_valid = 1'b1;
    rf_paddr = f;
    rf_data  = random_line();
    mg_valid = 1'b1;
    mg_data  = random_line();
    mg_be    = 16'h0ff0;
    run_cycle();
    // store loses to the refill of the same line
    clear_inputs();
    rf_valid = 1'b1;
    rf_paddr = g;
    rf_data  = random_line();
    st_valid = 1'b1;
    st_paddr = g;
    st_data  = random_line();
    st_be    = '1;
    run_cycle();
    clear_inputs();
    rd_valid    = 2'b11;
    rd_paddr[0] = f;
    rd_paddr[1] = g;
    run_cycle();
    finish_test("refill_merge", e0);
  endtask

  task automatic test_random_mix();
    int          e0;
    logic [31:0] r;
    logic [31:0] r2;
    e0 = err_count;
    for (int i = 0; i < 100; i++) begin
      clear_inputs();
      r           = lcg_next();
      r2          = lcg_next();
      rd_valid    = r[31:30];
      rd_paddr[0] = random_addr();
      rd_paddr[1] = random_addr();
      st_valid    = r[29];
      st_paddr    = random_addr();
      st_data     = random_line();
      st_be       = r2[31:16];
      rf_valid    = r[28] & r[27];
      rf_paddr    = random_addr();
      rf_data     = random_line();
      mg_valid    = r[26];
      mg_data     = random_line();
      mg_be       = r2[23:8];
      run_cycle();
    end
    finish_test("random_mix", e0);
  endtask

  initial begin
    rng_state    = 32'h08ea_eccc;
    err_count    = 0;
    tests_passed = 0;
    tests_failed = 0;
    reset_n      = 1'b0;
    clear_inputs();
    for (int b = 0; b < `DC_BANKS; b++) begin
      for (int s = 0; s < `DC_SETS; s++) begin
        m_valid[b][s] = 1'b0;
      end
    end
    repeat (2) @(negedge clk);
    reset_n = 1'b1;
    test_reset_miss();
    test_refill_hit();
    test_store_bytes();
    test_port_conflict();
    test_refill_merge();
    test_random_mix();
    $display("tests passed: %0d, tests failed: %0d, errors: %0d",
             tests_passed, tests_failed, err_count);
    if (tests_failed == 0 && err_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+src
src/dcache_pkg.sv
src/dcache_wr_merge.sv
src/dcache_bank.sv
src/dcache_rd_route.sv
src/dcache_top.sv
sim/tb_dcache.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - include_dirs:
      - src
    files:
      - src/dcache_pkg.sv
      - src/dcache_wr_merge.sv
      - src/dcache_bank.sv
      - src/dcache_rd_route.sv
      - src/dcache_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - sim/tb_dcache.sv
